//--- rtl/cache_settings.svh
// Word, address, cache depth, memory depth and memory latency settings for the cache subsystem.
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// ----------------------------------------
// Bus widths
// ----------------------------------------

// Data word width in bits.
`define CACHE_WORD_W 32

// Word address width. All addresses count words, not bytes.
`define CACHE_ADDR_W 10

// ----------------------------------------
// Cache and memory sizes
// ----------------------------------------

// Lines per cache, one word each. Must be a power of two.
`define CACHE_LINES 16

// Main memory depth in words.
`define MEM_WORDS 1024

// Cycles main memory holds busy before an access completes.
`define MEM_LATENCY 4

`endif

//--- rtl/cache_pkg.sv
// Bus request and response structs, address field types and the cache address union.
`include "cache_settings.svh"

package cache_pkg;

    // ----------------------------------------
    // Basic field types
    // ----------------------------------------

    typedef logic [`CACHE_WORD_W-1:0] word_t;
    typedef logic [`CACHE_ADDR_W-1:0] addr_t;

    // The index selects a line and the tag keeps the rest of the address.
    typedef logic [$clog2(`CACHE_LINES)-1:0] index_t;
    typedef logic [`CACHE_ADDR_W-$clog2(`CACHE_LINES)-1:0] tag_t;

    // ----------------------------------------
    // Bus types
    // ----------------------------------------

    // Request side. Only one of ren and wen may be high.
    typedef struct packed {
        logic  ren;
        logic  wen;
        addr_t addr;
        word_t wdata;
    } bus_req_t;

    // Response side. rdata is valid when busy is low under a read.
    typedef struct packed {
        logic  busy;
        word_t rdata;
    } bus_rsp_t;

    // Cache view of an address, tag in the upper bits.
    typedef struct packed {
        tag_t   tag;
        index_t index;
    } cache_field_t;

    // The same address word seen flat by memory and split by the cache.
    typedef union packed {
        addr_t        word_addr;
        cache_field_t fields;
    } cache_addr_t;

endpackage

//--- rtl/direct_mapped_cache.sv
// Direct-mapped write-back cache with one-word lines, flush and clear walks and a miss strobe.
`timescale 1ns/100ps
`include "cache_settings.svh"

module direct_mapped_cache (
    input  logic                CLK,
    input  logic                reset,
    input  cache_pkg::bus_req_t proc_req,
    output cache_pkg::bus_rsp_t proc_rsp,
    output cache_pkg::bus_req_t mem_req,
    input  cache_pkg::bus_rsp_t mem_rsp,
    input  logic                flush,
    input  logic                clear,
    output logic                flush_done,
    output logic                clear_done,
    output logic                cache_miss
);
    import cache_pkg::*;

    typedef enum logic [2:0] {
        s_idle,
        s_write_back,
        s_fill,
        s_flush_walk,
        s_clear_walk
    } state_t;

    state_t                  state;
    index_t                  walk_line;    // Line under the flush or clear walk.
    logic                    flush_pending;
    logic                    clear_pending;
    logic [`CACHE_LINES-1:0] valid;
    logic [`CACHE_LINES-1:0] dirty;
    tag_t                    tag_array  [`CACHE_LINES];
    word_t                   data_array [`CACHE_LINES];

    cache_addr_t proc_addr;
    cache_addr_t victim_addr;
    index_t      sel_index;
    logic        proc_active;
    logic        hit;
    logic        serve;
    logic        start_flush;
    logic        start_clear;
    logic        line_dirty;
    logic        walk_last;

    // ----------------------------------------
    // Lookup
    // ----------------------------------------

    assign proc_addr.word_addr = proc_req.addr;
    assign proc_active = proc_req.ren | proc_req.wen;
    assign hit = valid[proc_addr.fields.index]
        && (tag_array[proc_addr.fields.index] == proc_addr.fields.tag);

    // A flush or clear pulse takes the cache away from the processor at once.
    assign start_flush = flush | flush_pending;
    assign start_clear = clear | clear_pending;
    assign serve       = (state == s_idle) && !start_flush && !start_clear;

    // The walk addresses lines by counter, everything else by the request.
    assign sel_index  = (state == s_flush_walk) ? walk_line : proc_addr.fields.index;
    assign line_dirty = valid[sel_index] && dirty[sel_index];
    assign walk_last  = (walk_line == index_t'(`CACHE_LINES - 1));

    always_comb begin
        victim_addr.fields.tag   = tag_array[sel_index];  // Rebuild the evicted address.
        victim_addr.fields.index = sel_index;
    end

    assign proc_rsp.busy  = proc_active && !(serve && hit);
    assign proc_rsp.rdata = data_array[proc_addr.fields.index];
    assign cache_miss     = serve && proc_active && !hit;  // Only the first miss cycle is idle.

    // ----------------------------------------
    // Memory side requests
    // ----------------------------------------

    always_comb begin
        mem_req = '0;
        case (state)
            s_write_back: begin
                mem_req.wen   = 1'b1;
                mem_req.addr  = victim_addr.word_addr;
                mem_req.wdata = data_array[sel_index];
            end
            s_fill: begin
                mem_req.ren  = 1'b1;
                mem_req.addr = proc_req.addr;  // The processor holds its request through the fill.
            end
            s_flush_walk: begin
                mem_req.wen   = line_dirty;  // Clean lines are skipped without a memory access.
                mem_req.addr  = victim_addr.word_addr;
                mem_req.wdata = data_array[sel_index];
            end
            default: begin
                mem_req = '0;
            end
        endcase
    end

    // ----------------------------------------
    // Control state
    // ----------------------------------------

    always_ff @(posedge CLK) begin
        if (reset) begin
            state         <= s_idle;
            walk_line     <= '0;
            flush_pending <= 1'b0;
            clear_pending <= 1'b0;
            valid         <= '0;
            dirty         <= '0;
            flush_done    <= 1'b0;
            clear_done    <= 1'b0;
        end else begin
            flush_done <= 1'b0;
            clear_done <= 1'b0;
            if (flush) flush_pending <= 1'b1;  // Kept until the walk can start.
            if (clear) clear_pending <= 1'b1;
            case (state)
                s_idle: begin
                    walk_line <= '0;
                    if (start_flush) begin
                        flush_pending <= 1'b0;
                        state         <= s_flush_walk;
                    end else if (start_clear) begin
                        clear_pending <= 1'b0;
                        state         <= s_clear_walk;
                    end else if (proc_active && !hit) begin
                        state <= line_dirty ? s_write_back : s_fill;
                    end else if (proc_req.wen && hit) begin
                        dirty[proc_addr.fields.index] <= 1'b1;
                    end
                end
                s_write_back: begin
                    if (!mem_rsp.busy) state <= s_fill;
                end
                s_fill: begin
                    // The held request hits on the next idle cycle.
                    if (!mem_rsp.busy) begin
                        valid[proc_addr.fields.index] <= 1'b1;
                        dirty[proc_addr.fields.index] <= 1'b0;
                        state                         <= s_idle;
                    end
                end
                s_flush_walk: begin
                    if (!line_dirty || !mem_rsp.busy) begin
                        dirty[walk_line] <= 1'b0;
                        walk_line        <= walk_line + 1'b1;
                        if (walk_last) begin
                            flush_done <= 1'b1;
                            state      <= s_idle;
                        end
                    end
                end
                s_clear_walk: begin
                    valid[walk_line] <= 1'b0;  // One line per cycle.
                    dirty[walk_line] <= 1'b0;
                    walk_line        <= walk_line + 1'b1;
                    if (walk_last) begin
                        clear_done <= 1'b1;
                        state      <= s_idle;
                    end
                end
                default: state <= s_idle;
            endcase
        end
    end

    // Tag and data arrays take a refill or a write hit.
    always_ff @(posedge CLK) begin
        if (state == s_fill && !mem_rsp.busy) begin
            data_array[proc_addr.fields.index] <= mem_rsp.rdata;
            tag_array[proc_addr.fields.index]  <= proc_addr.fields.tag;
        end else if (serve && proc_req.wen && hit) begin
            data_array[proc_addr.fields.index] <= proc_req.wdata;
        end
    end

endmodule

//--- rtl/separate_caches.sv
// Split instruction and data caches with control routing and the fetch hold during data flushes.
`timescale 1ns/100ps

module separate_caches (
    input  logic                CLK,
    input  logic                reset,
    input  cache_pkg::bus_req_t icache_req,
    input  cache_pkg::bus_req_t dcache_req,
    output cache_pkg::bus_rsp_t icache_rsp,
    output cache_pkg::bus_rsp_t dcache_rsp,
    output cache_pkg::bus_req_t imem_req,
    output cache_pkg::bus_req_t dmem_req,
    input  cache_pkg::bus_rsp_t imem_rsp,
    input  cache_pkg::bus_rsp_t dmem_rsp,
    input  logic                icache_flush,
    input  logic                icache_clear,
    input  logic                dcache_flush,
    input  logic                dcache_clear,
    output logic                iflush_done,
    output logic                iclear_done,
    output logic                dflush_done,
    output logic                dclear_done,
    output logic                icache_miss,
    output logic                dcache_miss
);
    import cache_pkg::*;

    bus_req_t icache_fwd_req;
    bus_rsp_t icache_raw_rsp;
    logic     dflush_active;
    logic     ifetch_open;   // A fetch already inside the I$ is allowed to finish.
    logic     ifetch_hold;

    // ----------------------------------------
    // Fetch hold during a data flush
    // ----------------------------------------

    always_ff @(posedge CLK) begin
        if (reset) begin
            dflush_active <= 1'b0;
            ifetch_open   <= 1'b0;
        end else begin
            if (dcache_flush) dflush_active <= 1'b1;
            else if (dflush_done) dflush_active <= 1'b0;
            ifetch_open <= (icache_fwd_req.ren | icache_fwd_req.wen) & icache_raw_rsp.busy;
        end
    end

    // New fetches wait until memory holds the flushed data.
    assign ifetch_hold = (dcache_flush | dflush_active) & ~ifetch_open;

    always_comb begin
        icache_fwd_req = ifetch_hold ? '0 : icache_req;
        icache_rsp     = icache_raw_rsp;
        if (ifetch_hold) icache_rsp.busy = icache_req.ren | icache_req.wen;
    end

    // ----------------------------------------
    // Cache instances
    // ----------------------------------------

    direct_mapped_cache icache (
        .CLK       (CLK),
        .reset     (reset),
        .proc_req  (icache_fwd_req),
        .proc_rsp  (icache_raw_rsp),
        .mem_req   (imem_req),
        .mem_rsp   (imem_rsp),
        .flush     (icache_flush),
        .clear     (icache_clear),
        .flush_done(iflush_done),
        .clear_done(iclear_done),
        .cache_miss(icache_miss)
    );

    direct_mapped_cache dcache (
        .CLK       (CLK),
        .reset     (reset),
        .proc_req  (dcache_req),
        .proc_rsp  (dcache_rsp),
        .mem_req   (dmem_req),
        .mem_rsp   (dmem_rsp),
        .flush     (dcache_flush),
        .clear     (dcache_clear),
        .flush_done(dflush_done),
        .clear_done(dclear_done),
        .cache_miss(dcache_miss)
    );

endmodule

//--- rtl/mem_arbiter.sv
// Fixed-priority arbiter joining the instruction and data cache memory buses onto one memory bus.
`timescale 1ns/100ps

module mem_arbiter (
    input  logic                CLK,
    input  logic                reset,
    input  cache_pkg::bus_req_t imem_req,
    input  cache_pkg::bus_req_t dmem_req,
    output cache_pkg::bus_rsp_t imem_rsp,
    output cache_pkg::bus_rsp_t dmem_rsp,
    output cache_pkg::bus_req_t mem_req,
    input  cache_pkg::bus_rsp_t mem_rsp
);
    import cache_pkg::*;

    logic granted;   // An access is in progress on memory.
    logic owner_d;   // Set while the data cache owns that access.
    logic i_act;
    logic d_act;
    logic sel_d;

    assign i_act = imem_req.ren | imem_req.wen;
    assign d_act = dmem_req.ren | dmem_req.wen;

    // The data cache wins a tie. A held grant overrides the priority.
    assign sel_d = granted ? owner_d : d_act;

    // ----------------------------------------
    // Request and response routing
    // ----------------------------------------

    always_comb begin
        mem_req        = sel_d ? dmem_req : imem_req;
        imem_rsp.rdata = mem_rsp.rdata;
        dmem_rsp.rdata = mem_rsp.rdata;

        // The cache that is not served stalls on its own request.
        imem_rsp.busy = sel_d ? i_act : mem_rsp.busy;
        dmem_rsp.busy = sel_d ? mem_rsp.busy : d_act;
    end

    // ----------------------------------------
    // Grant register
    // ----------------------------------------

    always_ff @(posedge CLK) begin
        if (reset) begin
            granted <= 1'b0;
            owner_d <= 1'b0;
        end else if (!granted) begin
            if ((i_act | d_act) && mem_rsp.busy) begin
                granted <= 1'b1;
                owner_d <= sel_d;
            end
        end else if (!mem_rsp.busy) begin
            granted <= 1'b0;  // The served access completed.
        end
    end

endmodule

//--- rtl/main_memory.sv
// Word-wide main memory with a fixed access latency and a reset-time fill pattern.
`timescale 1ns/100ps
`include "cache_settings.svh"

module main_memory (
    input  logic                CLK,
    input  logic                reset,
    input  cache_pkg::bus_req_t mem_req,
    output cache_pkg::bus_rsp_t mem_rsp
);
    import cache_pkg::*;

    typedef logic [$clog2(`MEM_LATENCY + 1)-1:0] lat_count_t;

    word_t      mem_array [`MEM_WORDS];
    lat_count_t count;
    logic       active;
    logic       expired;

    assign active  = mem_req.ren | mem_req.wen;
    assign expired = (count == lat_count_t'(`MEM_LATENCY));

    // Busy covers the latency cycles and drops in the cycle that completes the access.
    assign mem_rsp.busy  = active & ~expired;
    assign mem_rsp.rdata = mem_array[mem_req.addr];

    // ----------------------------------------
    // Latency counter
    // ----------------------------------------

    always_ff @(posedge CLK) begin
        if (reset) begin
            count <= '0;
        end else if (active) begin
            count <= expired ? '0 : count + 1'b1;  // Restarts for a back-to-back request.
        end else begin
            count <= '0;
        end
    end

    // ----------------------------------------
    // Storage
    // ----------------------------------------

    // Reset loads a known pattern so untouched words can be checked.
    always_ff @(posedge CLK) begin
        if (reset) begin
            for (int a = 0; a < `MEM_WORDS; a++) begin
                mem_array[a] <= word_t'(a) ^ word_t'(32'hC0DE0000);
            end
        end else if (active && mem_req.wen && expired) begin
            mem_array[mem_req.addr] <= mem_req.wdata;
        end
    end

endmodule

//--- rtl/cache_subsystem.sv
// Top level joining the split caches, the memory arbiter and main memory.
`timescale 1ns/100ps

module cache_subsystem (
    input  logic                CLK,
    input  logic                reset,
    input  cache_pkg::bus_req_t icache_req,
    input  cache_pkg::bus_req_t dcache_req,
    output cache_pkg::bus_rsp_t icache_rsp,
    output cache_pkg::bus_rsp_t dcache_rsp,
    input  logic                icache_flush,
    input  logic                icache_clear,
    input  logic                dcache_flush,
    input  logic                dcache_clear,
    output logic                iflush_done,
    output logic                iclear_done,
    output logic                dflush_done,
    output logic                dclear_done,
    output logic                icache_miss,
    output logic                dcache_miss
);
    import cache_pkg::*;

    bus_req_t imem_req;
    bus_req_t dmem_req;
    bus_rsp_t imem_rsp;
    bus_rsp_t dmem_rsp;
    bus_req_t mem_req;
    bus_rsp_t mem_rsp;

    separate_caches caches_i (
        .CLK         (CLK),
        .reset       (reset),
        .icache_req  (icache_req),
        .dcache_req  (dcache_req),
        .icache_rsp  (icache_rsp),
        .dcache_rsp  (dcache_rsp),
        .imem_req    (imem_req),
        .dmem_req    (dmem_req),
        .imem_rsp    (imem_rsp),
        .dmem_rsp    (dmem_rsp),
        .icache_flush(icache_flush),
        .icache_clear(icache_clear),
        .dcache_flush(dcache_flush),
        .dcache_clear(dcache_clear),
        .iflush_done (iflush_done),
        .iclear_done (iclear_done),
        .dflush_done (dflush_done),
        .dclear_done (dclear_done),
        .icache_miss (icache_miss),
        .dcache_miss (dcache_miss)
    );

    // Both caches share the single memory port.
    mem_arbiter arbiter_i (
        .CLK     (CLK),
        .reset   (reset),
        .imem_req(imem_req),
        .dmem_req(dmem_req),
        .imem_rsp(imem_rsp),
        .dmem_rsp(dmem_rsp),
        .mem_req (mem_req),
        .mem_rsp (mem_rsp)
    );

    main_memory memory_i (
        .CLK    (CLK),
        .reset  (reset),
        .mem_req(mem_req),
        .mem_rsp(mem_rsp)
    );

endmodule

//--- verif/cache_subsystem_tb.sv
// Data-driven testbench for the cache subsystem with clock, reset, case reader and compare tasks.
`timescale 1ns/100ps

module cache_subsystem_tb;
    import cache_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic     CLK;
    logic     reset;
    bus_req_t icache_req;
    bus_req_t dcache_req;
    bus_rsp_t icache_rsp;
    bus_rsp_t dcache_rsp;
    logic     icache_flush;
    logic     icache_clear;
    logic     dcache_flush;
    logic     dcache_clear;
    logic     iflush_done;
    logic     iclear_done;
    logic     dflush_done;
    logic     dclear_done;
    logic     icache_miss;
    logic     dcache_miss;
    int       case_count;   // Number of the case in progress, for error lines.

    cache_subsystem cache_subsystem_i (
        .CLK         (CLK),
        .reset       (reset),
        .icache_req  (icache_req),
        .dcache_req  (dcache_req),
        .icache_rsp  (icache_rsp),
        .dcache_rsp  (dcache_rsp),
        .icache_flush(icache_flush),
        .icache_clear(icache_clear),
        .dcache_flush(dcache_flush),
        .dcache_clear(dcache_clear),
        .iflush_done (iflush_done),
        .iclear_done (iclear_done),
        .dflush_done (dflush_done),
        .dclear_done (dclear_done),
        .icache_miss (icache_miss),
        .dcache_miss (dcache_miss)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;  // 10 ns period.
    end

    // ----------------------------------------
    // Helpers and compare tasks
    // ----------------------------------------

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic stop_on_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    task automatic check_rsp(input string name, input bus_rsp_t rsp, input word_t expected);
        if (rsp.rdata !== expected) begin
            stop_on_failure($sformatf("Mismatch %s.rdata in case %0d: got 0x%h, expected 0x%h",
                                      name, case_count, rsp.rdata, expected));
        end
    endtask

    task automatic check_miss(input string name, input logic seen, input logic expected);
        if (seen !== expected) begin
            stop_on_failure($sformatf("Mismatch %s in case %0d: got 0x%h, expected 0x%h",
                                      name, case_count, seen, expected));
        end
    endtask

    // ----------------------------------------
    // Bus and control sequences
    // ----------------------------------------

    // Holds the request on the chosen ports until each has seen busy low.
    task automatic run_access(input logic use_i, input logic use_d, input logic is_write,
                              input addr_t addr, input word_t wdata,
                              output bus_rsp_t i_rsp, output bus_rsp_t d_rsp,
                              output logic i_miss, output logic d_miss);
        bus_req_t req;
        logic     i_done;
        logic     d_done;
        int       cycles;
        req.ren   = ~is_write;
        req.wen   = is_write;
        req.addr  = addr;
        req.wdata = wdata;
        i_rsp     = '0;
        d_rsp     = '0;
        i_miss    = 1'b0;
        d_miss    = 1'b0;
        i_done    = ~use_i;
        d_done    = ~use_d;
        cycles    = 0;
        @(negedge CLK);
        if (use_i) icache_req = req;
        if (use_d) dcache_req = req;
        while (!(i_done && d_done)) begin
            #1;  // Outputs are settled well before the next rising edge.
            i_miss = i_miss | (use_i & icache_miss);
            d_miss = d_miss | (use_d & dcache_miss);
            if (!i_done && !icache_rsp.busy) begin
                i_rsp  = icache_rsp;
                i_done = 1'b1;
            end
            if (!d_done && !dcache_rsp.busy) begin
                d_rsp  = dcache_rsp;
                d_done = 1'b1;
            end
            if (!(i_done && d_done)) begin
                if (cycles == TIMEOUT_CYCLES) begin
                    stop_on_failure($sformatf("Case %0d timed out waiting for busy to fall.",
                                              case_count));
                end else begin
                    cycles++;
                    @(negedge CLK);
                end
            end
        end
        @(negedge CLK);
        icache_req = '0;
        dcache_req = '0;
    endtask

    // One flush or clear pulse, then wait for the matching done pulse.
    task automatic run_control(input logic is_data, input logic is_flush);
        logic seen;
        int   cycles;
        @(negedge CLK);
        dcache_flush = is_data & is_flush;
        dcache_clear = is_data & ~is_flush;
        icache_flush = ~is_data & is_flush;
        icache_clear = ~is_data & ~is_flush;
        @(negedge CLK);
        {icache_flush, icache_clear, dcache_flush, dcache_clear} = '0;
        seen   = 1'b0;
        cycles = 0;
        while (!seen) begin
            #1;
            case ({is_data, is_flush})
                2'b11:   seen = dflush_done;
                2'b10:   seen = dclear_done;
                2'b01:   seen = iflush_done;
                default: seen = iclear_done;
            endcase
            if (!seen) begin
                if (cycles == TIMEOUT_CYCLES) begin
                    stop_on_failure($sformatf("Case %0d timed out waiting for the done pulse.",
                                              case_count));
                end else begin
                    cycles++;
                    @(negedge CLK);
                end
            end
        end
    endtask

    task automatic run_case(input logic [63:0] op_text, input logic [63:0] port_text,
                            input addr_t addr, input word_t wdata, input word_t expected,
                            input int exp_miss);
        logic     use_i;
        logic     use_d;
        logic     is_write;
        bus_rsp_t i_rsp;
        bus_rsp_t d_rsp;
        logic     i_miss;
        logic     d_miss;
        use_i    = (port_text == "i") || (port_text == "b");  // Port b drives both caches.
        use_d    = (port_text == "d") || (port_text == "b");
        is_write = (op_text == "write");
        if (!use_i && !use_d) begin
            stop_on_failure($sformatf("Case %0d names an unknown port.", case_count));
        end else if (op_text == "read" || op_text == "write") begin
            run_access(use_i, use_d, is_write, addr, wdata, i_rsp, d_rsp, i_miss, d_miss);
            if (use_i) check_miss("icache_miss", i_miss, exp_miss != 0);
            if (use_d) check_miss("dcache_miss", d_miss, exp_miss != 0);
            if (use_i && !is_write) check_rsp("icache_rsp", i_rsp, expected);
            if (use_d && !is_write) check_rsp("dcache_rsp", d_rsp, expected);
        end else if (op_text == "flush" || op_text == "clear") begin
            run_control(use_d, op_text == "flush");
        end else begin
            stop_on_failure($sformatf("Case %0d names an unknown operation.", case_count));
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        int          fd;
        int          n;
        int          c;
        int          exp_miss;
        logic [63:0] op_text;
        logic [63:0] port_text;
        addr_t       addr;
        word_t       wdata;
        word_t       expected;
        logic [31:0] rng;
        icache_req   = '0;
        dcache_req   = '0;
        icache_flush = 1'b0;
        icache_clear = 1'b0;
        dcache_flush = 1'b0;
        dcache_clear = 1'b0;
        reset        = 1'b1;
        case_count   = 0;
        rng          = 32'd99;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        reset = 1'b0;

        fd = $fopen("verif/cache_cases.txt", "r");
        if (fd == 0) stop_on_failure("Could not open the case file verif/cache_cases.txt.");
        while ($fscanf(fd, "%s", op_text) == 1) begin
            if (op_text == "#") begin
                c = $fgetc(fd);  // Skip the rest of a comment line.
                while (c != "\n" && c != -1) c = $fgetc(fd);
            end else begin
                n = $fscanf(fd, "%s %h %h %h %d", port_text, addr, wdata, expected, exp_miss);
                case_count++;
                if (n != 5) begin
                    stop_on_failure($sformatf("Case %0d in the case file is incomplete.",
                                              case_count));
                end else begin
                    rng = xorshift32(rng);
                    repeat (rng % 4) @(negedge CLK);  // Random idle gap between cases.
                    run_case(op_text, port_text, addr, wdata, expected, exp_miss);
                end
            end
        end
        $fclose(fd);

        if (case_count == 0) begin
            stop_on_failure("The case file held no cases.");
        end else begin
            $display("Completed %0d cases.", case_count);
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

//--- verif/cache_cases.txt
# op port addr wdata expected miss, all values hex except miss (0 or 1)
# expected data is checked on reads only; port b reads both caches at once
read  i 010 00000000 c0de0010 1
read  i 010 00000000 c0de0010 0
read  d 025 00000000 c0de0025 1
read  d 025 00000000 c0de0025 0
write d 033 deadbeef 00000000 1
read  d 033 00000000 deadbeef 0
read  i 033 00000000 c0de0033 1
flush d 000 00000000 00000000 0
read  i 033 00000000 c0de0033 0
clear i 000 00000000 00000000 0
read  i 033 00000000 deadbeef 1
write d 047 11111111 00000000 1
write d 087 22222222 00000000 1
read  d 047 00000000 11111111 1
read  d 087 00000000 22222222 1
read  d 025 00000000 c0de0025 0
write d 025 33333333 00000000 0
read  d 025 00000000 33333333 0
clear d 000 00000000 00000000 0
read  d 025 00000000 c0de0025 1
read  d 033 00000000 deadbeef 1
flush i 000 00000000 00000000 0
read  b 1a2 00000000 c0de01a2 1
read  b 1a2 00000000 c0de01a2 0
read  b 3f0 00000000 c0de03f0 1
read  d 3f0 00000000 c0de03f0 0
read  i 3f0 00000000 c0de03f0 0

//--- compile.f
+incdir+rtl
rtl/cache_pkg.sv
rtl/direct_mapped_cache.sv
rtl/separate_caches.sv
rtl/mem_arbiter.sv
rtl/main_memory.sv
rtl/cache_subsystem.sv
verif/cache_subsystem_tb.sv

//--- Bender.yml
package:
  name: cache_subsystem

export_include_dirs:
  - rtl

sources:
  - files:
      - rtl/cache_pkg.sv
      - rtl/direct_mapped_cache.sv
      - rtl/separate_caches.sv
      - rtl/mem_arbiter.sv
      - rtl/main_memory.sv
      - rtl/cache_subsystem.sv
  - target: test
    files:
      - verif/cache_subsystem_tb.sv
